//--- verilog/memBusPkg.sv
package memBusPkg;

    // external RAM is byte wide, core side is word wide
    localparam int unsigned addrWidth = 32;
    localparam int unsigned byteWidth = 8;
    localparam int unsigned wordWidth = 32;

    localparam int unsigned bytesPerWord = wordWidth / byteWidth;

    // address increment between consecutive bytes of a burst
    localparam int unsigned addrStep = 1;

    // size of the attached RAM, as a power of two
    localparam int unsigned ramDepthLog2 = 12;

    typedef logic [addrWidth-1:0] addr_t;
    typedef logic [byteWidth-1:0] byte_t;
    typedef logic [wordWidth-1:0] word_t;

endpackage

//--- verilog/memOpPkg.sv
package memOpPkg;

    // value is the byte count of the access
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_e;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } loadStore_e;

    // which port currently drives the RAM
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerFetch = 2'd1,
        ownerData  = 2'd2
    } busOwner_e;

    // shared by both port sequencers
    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stXfer = 2'd1,
        stDone = 2'd2
    } portState_e;

endpackage

//--- verilog/memPortIf.sv
`timescale 1ns/1ps

interface memPortIf;

    // port side of the burst
    logic             req;
    logic             last;
    logic             write;
    memBusPkg::addr_t addr;
    memBusPkg::byte_t wdata;

    // arbiter side
    logic             grant;
    memBusPkg::byte_t rdata;

    modport port (
        output req,
        output last,
        output write,
        output addr,
        output wdata,
        input  grant,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  last,
        input  write,
        input  addr,
        input  wdata,
        output grant,
        output rdata
    );

endinterface

//--- verilog/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic                clk,
    input  logic                rst,
    memPortIf.arbiter           fetchBus,
    memPortIf.arbiter           dataBus,
    output memBusPkg::addr_t    memAddr,
    output logic                memWrite,
    output memBusPkg::byte_t    memWdata,
    input  memBusPkg::byte_t    memRdata,
    output memOpPkg::busOwner_e busOwner
);

    memOpPkg::busOwner_e owner;
    memOpPkg::busOwner_e nextOwner;

    // ownership only changes on an idle bus or on the owner's last byte
    always_comb begin
        nextOwner = owner;
        case (owner)
            memOpPkg::ownerNone: begin
                if (dataBus.req) begin
                    nextOwner = memOpPkg::ownerData;
                end else if (fetchBus.req) begin
                    nextOwner = memOpPkg::ownerFetch;
                end
            end
            memOpPkg::ownerFetch: begin
                if (fetchBus.last) begin
                    nextOwner = dataBus.req ? memOpPkg::ownerData : memOpPkg::ownerNone;
                end
            end
            memOpPkg::ownerData: begin
                // hand over straight to a waiting fetch
                if (dataBus.last) begin
                    nextOwner = fetchBus.req ? memOpPkg::ownerFetch : memOpPkg::ownerNone;
                end
            end
            default: begin
                nextOwner = memOpPkg::ownerNone;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= memOpPkg::ownerNone;
        end else begin
            owner <= nextOwner;
        end
    end

    assign fetchBus.grant = (owner == memOpPkg::ownerFetch);
    assign dataBus.grant  = (owner == memOpPkg::ownerData);

    // read data goes to both, each port tracks its own beats
    assign fetchBus.rdata = memRdata;
    assign dataBus.rdata  = memRdata;

    always_comb begin
        memAddr  = fetchBus.addr;
        memWdata = fetchBus.wdata;
        memWrite = 1'b0;
        case (owner)
            memOpPkg::ownerFetch: begin
                memWrite = fetchBus.write;
            end
            memOpPkg::ownerData: begin
                memAddr  = dataBus.addr;
                memWdata = dataBus.wdata;
                memWrite = dataBus.write;
            end
            default: begin
                memWrite = 1'b0;
            end
        endcase
    end

    assign busOwner = owner;

endmodule

//--- verilog/instFetchPort.sv
`timescale 1ns/1ps

module instFetchPort (
    input  logic             clk,
    input  logic             rst,
    memPortIf.port           bus,
    input  logic             fetchEn,
    input  memBusPkg::addr_t fetchAddr,
    output logic             fetchDone,
    output memBusPkg::word_t fetchInst
);

    memOpPkg::portState_e state;
    logic [1:0]           byteIdx;
    memBusPkg::addr_t     baseAddr;

    // read beat in flight, rdata belongs to lane rdLane
    logic                 rdValid;
    logic [1:0]           rdLane;

    memBusPkg::word_t     asmWord;
    memBusPkg::word_t     liveWord;
    memBusPkg::word_t     instHold;

    assign bus.req   = (state == memOpPkg::stIdle) && fetchEn;
    assign bus.last  = bus.grant && (byteIdx == 2'(memBusPkg::bytesPerWord - 1));
    assign bus.write = 1'b0;
    assign bus.wdata = '0;
    assign bus.addr  = baseAddr + memBusPkg::addr_t'(memBusPkg::addrStep * byteIdx);

    // first beat runs while still idle, grant alone marks it
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= memOpPkg::stIdle;
            byteIdx <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= bus.grant;
            case (state)
                memOpPkg::stIdle, memOpPkg::stXfer: begin
                    if (bus.grant) begin
                        if (bus.last) begin
                            state   <= memOpPkg::stDone;
                            byteIdx <= '0;
                        end else begin
                            state   <= memOpPkg::stXfer;
                            byteIdx <= byteIdx + 2'd1;
                        end
                    end
                end
                memOpPkg::stDone: begin
                    state <= memOpPkg::stIdle;
                end
                default: begin
                    state <= memOpPkg::stIdle;
                end
            endcase
        end
    end

    // little-endian lane insert of the byte now on rdata
    always_comb begin
        liveWord = asmWord;
        if (rdValid) begin
            liveWord[rdLane*memBusPkg::byteWidth +: memBusPkg::byteWidth] = bus.rdata;
        end
    end

    always_ff @(posedge clk) begin
        // address sampled while waiting, client holds it anyway
        if (bus.req && !bus.grant) begin
            baseAddr <= fetchAddr;
        end
        rdLane <= byteIdx;
        if (rdValid) begin
            asmWord <= liveWord;
        end
        if (state == memOpPkg::stDone) begin
            instHold <= liveWord;
        end
    end

    assign fetchDone = (state == memOpPkg::stDone);

    // last byte arrives in the done cycle itself
    assign fetchInst = fetchDone ? liveWord : instHold;

endmodule

//--- verilog/dataAccessPort.sv
`timescale 1ns/1ps

module dataAccessPort (
    input  logic                 clk,
    input  logic                 rst,
    memPortIf.port               bus,
    input  logic                 dataEn,
    input  memOpPkg::loadStore_e dataOp,
    input  memOpPkg::accessLen_e dataLen,
    input  memBusPkg::addr_t     dataAddr,
    input  memBusPkg::word_t     storeData,
    output logic                 dataDone,
    output memBusPkg::word_t     loadData
);

    memOpPkg::portState_e state;
    logic [1:0]           byteIdx;

    // request captured while waiting for grant
    memOpPkg::loadStore_e opReg;
    memOpPkg::accessLen_e lenReg;
    memBusPkg::addr_t     baseAddr;
    memBusPkg::word_t     storeReg;

    logic                 rdValid;
    logic [1:0]           rdLane;

    memBusPkg::word_t     asmWord;
    memBusPkg::word_t     liveWord;
    memBusPkg::word_t     maskedWord;
    memBusPkg::word_t     loadHold;

    assign bus.req   = (state == memOpPkg::stIdle) && dataEn;
    assign bus.last  = bus.grant && ((3'(byteIdx) + 3'd1) == lenReg);
    assign bus.write = bus.grant && (opReg == memOpPkg::opStore);
    assign bus.addr  = baseAddr + memBusPkg::addr_t'(memBusPkg::addrStep * byteIdx);
    assign bus.wdata = storeReg[byteIdx*memBusPkg::byteWidth +: memBusPkg::byteWidth];

    // a one-byte access is last already in its first beat
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= memOpPkg::stIdle;
            byteIdx <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= bus.grant && (opReg == memOpPkg::opLoad);
            case (state)
                memOpPkg::stIdle, memOpPkg::stXfer: begin
                    if (bus.grant) begin
                        if (bus.last) begin
                            state   <= memOpPkg::stDone;
                            byteIdx <= '0;
                        end else begin
                            state   <= memOpPkg::stXfer;
                            byteIdx <= byteIdx + 2'd1;
                        end
                    end
                end
                memOpPkg::stDone: begin
                    state <= memOpPkg::stIdle;
                end
                default: begin
                    state <= memOpPkg::stIdle;
                end
            endcase
        end
    end

    always_comb begin
        liveWord = asmWord;
        if (rdValid) begin
            liveWord[rdLane*memBusPkg::byteWidth +: memBusPkg::byteWidth] = bus.rdata;
        end
    end

    // zero-extend, lanes at and above the length read as zero
    always_comb begin
        maskedWord = '0;
        for (int i = 0; i < memBusPkg::bytesPerWord; i++) begin
            if (i < int'(lenReg)) begin
                maskedWord[i*memBusPkg::byteWidth +: memBusPkg::byteWidth] =
                    liveWord[i*memBusPkg::byteWidth +: memBusPkg::byteWidth];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req && !bus.grant) begin
            opReg    <= dataOp;
            lenReg   <= dataLen;
            baseAddr <= dataAddr;
            storeReg <= storeData;
        end
        rdLane <= byteIdx;
        if (rdValid) begin
            asmWord <= liveWord;
        end
        if (state == memOpPkg::stDone && opReg == memOpPkg::opLoad) begin
            loadHold <= maskedWord;
        end
    end

    assign dataDone = (state == memOpPkg::stDone);

    // stores leave the previous load result in place
    assign loadData = (dataDone && opReg == memOpPkg::opLoad) ? maskedWord : loadHold;

endmodule

//--- verilog/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic                 clk,
    input  logic                 rst,

    // byte RAM, read data one cycle after address
    output memBusPkg::addr_t     memAddr,
    output logic                 memWrite,
    output memBusPkg::byte_t     memWdata,
    input  memBusPkg::byte_t     memRdata,

    input  logic                 fetchEn,
    input  memBusPkg::addr_t     fetchAddr,
    output logic                 fetchDone,
    output memBusPkg::word_t     fetchInst,

    input  logic                 dataEn,
    input  memOpPkg::loadStore_e dataOp,
    input  memOpPkg::accessLen_e dataLen,
    input  memBusPkg::addr_t     dataAddr,
    input  memBusPkg::word_t     storeData,
    output logic                 dataDone,
    output memBusPkg::word_t     loadData,

    output memOpPkg::busOwner_e  busOwner
);

    memPortIf fetchBus ();
    memPortIf dataBus ();

    instFetchPort fetchPort (
        .clk       (clk),
        .rst       (rst),
        .bus       (fetchBus.port),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    dataAccessPort dataPort (
        .clk       (clk),
        .rst       (rst),
        .bus       (dataBus.port),
        .dataEn    (dataEn),
        .dataOp    (dataOp),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .storeData (storeData),
        .dataDone  (dataDone),
        .loadData  (loadData)
    );

    // data port wins a tie on an idle bus
    memArbiter arbiter (
        .clk      (clk),
        .rst      (rst),
        .fetchBus (fetchBus.arbiter),
        .dataBus  (dataBus.arbiter),
        .memAddr  (memAddr),
        .memWrite (memWrite),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .busOwner (busOwner)
    );

endmodule

//--- verif/memCtrl_asserts.sv
`timescale 1ns/1ps

module memCtrlAsserts (
    input logic                clk,
    input logic                rst,
    input logic                memWrite,
    input memOpPkg::busOwner_e busOwner,
    input logic                fetchDone,
    input logic                dataDone,
    input logic                fetchGrant,
    input logic                dataGrant
);

    // only the data port ever writes
    writeByData: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> busOwner == memOpPkg::ownerData)
        else $error("memWrite high while busOwner is %0d", busOwner);

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone held longer than one cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone held longer than one cycle");

    grantsExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchGrant && dataGrant))
        else $error("both ports granted at once");

endmodule

bind memCtrl memCtrlAsserts busChecks (
    .clk        (clk),
    .rst        (rst),
    .memWrite   (memWrite),
    .busOwner   (busOwner),
    .fetchDone  (fetchDone),
    .dataDone   (dataDone),
    .fetchGrant (fetchBus.grant),
    .dataGrant  (dataBus.grant)
);

//--- verif/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb;

    localparam int clkPeriod = 40;
    localparam int ramDepth = 1 << memBusPkg::ramDepthLog2;
    localparam int fetchTests = 6;
    localparam int loadTests = 9;
    localparam int storeTests = 9;
    localparam int mixTests = 6;
    localparam int totalAccesses = fetchTests + loadTests + 2 * storeTests + 2 * mixTests;

    typedef logic [memBusPkg::ramDepthLog2-1:0] ramIdx_t;

    logic                 clk;
    logic                 rst;
    memBusPkg::addr_t     memAddr;
    logic                 memWrite;
    memBusPkg::byte_t     memWdata;
    memBusPkg::byte_t     memRdata;
    logic                 fetchEn;
    memBusPkg::addr_t     fetchAddr;
    logic                 fetchDone;
    memBusPkg::word_t     fetchInst;
    logic                 dataEn;
    memOpPkg::loadStore_e dataOp;
    memOpPkg::accessLen_e dataLen;
    memBusPkg::addr_t     dataAddr;
    memBusPkg::word_t     storeData;
    logic                 dataDone;
    memBusPkg::word_t     loadData;
    memOpPkg::busOwner_e  busOwner;

    memBusPkg::byte_t ram [0:ramDepth-1];
    memBusPkg::byte_t shadow [0:ramDepth-1];
    ramIdx_t          preAddrQ [$];
    memBusPkg::byte_t preDataQ [$];
    memBusPkg::word_t fetchQ [$];
    memBusPkg::word_t loadQ [$];
    bit               dataIsLoadQ [$];
    logic [31:0]      lfsr;

    memCtrl UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic memBusPkg::byte_t fillByte(input int idx);
        return memBusPkg::byte_t'((idx * 37) ^ (idx >> 5) ^ (idx >> 9));
    endfunction

    // fibonacci taps at bits 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic ramIdx_t ramIndex(input memBusPkg::addr_t a, input int offset);
        memBusPkg::addr_t full;
        full = a + memBusPkg::addr_t'(offset);
        return full[memBusPkg::ramDepthLog2-1:0];
    endfunction

    // little-endian bytes from the shadow copy with upper lanes zeroed
    function automatic memBusPkg::word_t expectedLoad(input memBusPkg::addr_t a, input int n);
        memBusPkg::word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[i*memBusPkg::byteWidth +: memBusPkg::byteWidth] = shadow[ramIndex(a, i)];
        end
        return w;
    endfunction

    function automatic memBusPkg::word_t assembledInst(input memBusPkg::addr_t a);
        return expectedLoad(a, int'(memBusPkg::bytesPerWord));
    endfunction

    function automatic memOpPkg::accessLen_e lenOf(input int idx);
        case (idx % 3)
            0: return memOpPkg::lenByte;
            1: return memOpPkg::lenHalf;
            default: return memOpPkg::lenWord;
        endcase
    endfunction

    task automatic stopWithError(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            stopWithError($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                                    name, expected, actual));
        end
    endtask

    // RAM model returns read data one cycle after the address
    initial begin
        for (int i = 0; i < ramDepth; i++) begin
            ram[ramIdx_t'(i)] = fillByte(i);
        end
        memRdata = '0;
        forever begin
            @(posedge clk);
            memRdata <= ram[memAddr[memBusPkg::ramDepthLog2-1:0]];
            if (memWrite) begin
                ram[memAddr[memBusPkg::ramDepthLog2-1:0]] = memWdata;
            end
            while (preAddrQ.size() > 0) begin
                ram[preAddrQ.pop_front()] = preDataQ.pop_front();
            end
        end
    end

    task automatic preloadWord(input memBusPkg::addr_t a, input memBusPkg::word_t w);
        ramIdx_t          idx;
        memBusPkg::byte_t b;
        for (int i = 0; i < int'(memBusPkg::bytesPerWord); i++) begin
            idx = ramIndex(a, i);
            b = w[i*memBusPkg::byteWidth +: memBusPkg::byteWidth];
            shadow[idx] = b;
            preAddrQ.push_back(idx);
            preDataQ.push_back(b);
        end
        @(negedge clk);
    endtask

    task automatic waitDone(input bit forData, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(forData ? dataDone : fetchDone));
    endtask

    // queue the expected result and apply stores to the shadow copy
    task automatic startData(input memOpPkg::loadStore_e op, input memOpPkg::accessLen_e len,
                             input memBusPkg::addr_t a, input memBusPkg::word_t d);
        if (op == memOpPkg::opLoad) begin
            loadQ.push_back(expectedLoad(a, int'(len)));
            dataIsLoadQ.push_back(1'b1);
        end else begin
            for (int i = 0; i < int'(len); i++) begin
                shadow[ramIndex(a, i)] = d[i*memBusPkg::byteWidth +: memBusPkg::byteWidth];
            end
            loadQ.push_back('0);
            dataIsLoadQ.push_back(1'b0);
        end
        dataOp = op;
        dataLen = len;
        dataAddr = a;
        storeData = d;
        dataEn = 1'b1;
    endtask

    task automatic fetchWord(input memBusPkg::addr_t a);
        int cycles;
        fetchQ.push_back(assembledInst(a));
        fetchAddr = a;
        fetchEn = 1'b1;
        waitDone(1'b0, cycles);
        fetchEn = 1'b0;
        checkValue("fetchLatency", 32'(memBusPkg::bytesPerWord + 1), 32'(cycles));
        @(negedge clk);
    endtask

    task automatic accessData(input memOpPkg::loadStore_e op, input memOpPkg::accessLen_e len,
                              input memBusPkg::addr_t a, input memBusPkg::word_t d);
        int cycles;
        startData(op, len, a, d);
        waitDone(1'b1, cycles);
        dataEn = 1'b0;
        checkValue("dataLatency", 32'(int'(len) + 1), 32'(cycles));
        @(negedge clk);
    endtask

    // both enables rise on the same edge and data must finish first
    task automatic runContention(input memBusPkg::addr_t fa, input memOpPkg::loadStore_e op,
                                 input memOpPkg::accessLen_e len, input memBusPkg::addr_t a,
                                 input memBusPkg::word_t d);
        int cycles;
        int dataAt;
        int fetchAt;
        startData(op, len, a, d);
        fetchQ.push_back(assembledInst(fa));
        fetchAddr = fa;
        fetchEn = 1'b1;
        cycles = 0;
        dataAt = 0;
        fetchAt = 0;
        while (dataAt == 0 || fetchAt == 0) begin
            @(negedge clk);
            cycles++;
            if (dataDone && dataAt == 0) begin
                dataAt = cycles;
                dataEn = 1'b0;
            end
            if (fetchDone && fetchAt == 0) begin
                fetchAt = cycles;
                fetchEn = 1'b0;
            end
        end
        checkValue("dataLatency", 32'(int'(len) + 1), 32'(dataAt));
        checkValue("doneOrder", 32'd1, 32'(dataAt < fetchAt));
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        memBusPkg::word_t expected;
        bit               isLoad;
        if (!rst && fetchDone) begin
            if (fetchQ.size() == 0) begin
                stopWithError("fetchDone pulsed with no fetch pending");
            end else begin
                expected = fetchQ.pop_front();
                checkValue("fetchInst", expected, fetchInst);
            end
        end
        if (!rst && dataDone) begin
            if (dataIsLoadQ.size() == 0) begin
                stopWithError("dataDone pulsed with no data access pending");
            end else begin
                isLoad = dataIsLoadQ.pop_front();
                expected = loadQ.pop_front();
                if (isLoad) begin
                    checkValue("loadData", expected, loadData);
                end
            end
        end
    end

    initial begin
        repeat (totalAccesses * 20 + 100) @(posedge clk);
        stopWithError("watchdog expired before all accesses completed");
    end

    initial begin
        memBusPkg::addr_t     a;
        memBusPkg::addr_t     fa;
        memBusPkg::word_t     d;
        memOpPkg::loadStore_e op;
        rst = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataOp = memOpPkg::opLoad;
        dataLen = memOpPkg::lenByte;
        dataAddr = '0;
        storeData = '0;
        lfsr = 32'he5cf97b7;
        for (int i = 0; i < ramDepth; i++) begin
            shadow[ramIdx_t'(i)] = fillByte(i);
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue("memWrite", 32'd0, 32'(memWrite));
        checkValue("fetchDone", 32'd0, 32'(fetchDone));
        checkValue("dataDone", 32'd0, 32'(dataDone));
        checkValue("busOwner", 32'(memOpPkg::ownerNone), 32'(busOwner));
        for (int i = 0; i < fetchTests; i++) begin
            a = memBusPkg::addr_t'(randBits(memBusPkg::ramDepthLog2));
            d = randBits(32);
            preloadWord(a, d);
            fetchWord(a);
        end
        for (int i = 0; i < loadTests; i++) begin
            a = memBusPkg::addr_t'(randBits(memBusPkg::ramDepthLog2));
            accessData(memOpPkg::opLoad, lenOf(i), a, '0);
        end
        // word readback shows the bytes around the store kept
        for (int i = 0; i < storeTests; i++) begin
            a = memBusPkg::addr_t'(randBits(memBusPkg::ramDepthLog2));
            d = randBits(32);
            accessData(memOpPkg::opStore, lenOf(i), a, d);
            accessData(memOpPkg::opLoad, memOpPkg::lenWord, a, '0);
        end
        for (int i = 0; i < mixTests; i++) begin
            fa = memBusPkg::addr_t'(randBits(memBusPkg::ramDepthLog2));
            a = memBusPkg::addr_t'(randBits(memBusPkg::ramDepthLog2));
            d = randBits(32);
            op = (randBits(1) != 0) ? memOpPkg::opStore : memOpPkg::opLoad;
            runContention(fa, op, lenOf(i), a, d);
        end
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- src.f
verilog/memBusPkg.sv
verilog/memOpPkg.sv
verilog/memPortIf.sv
verilog/memArbiter.sv
verilog/instFetchPort.sv
verilog/dataAccessPort.sv
verilog/memCtrl.sv
verif/memCtrl_asserts.sv
verif/memCtrlTb.sv

//--- Makefile
TOP := memCtrlTb
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
